// ==== cpu_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defines.svh"

module cpu_alu (
    input  wire cpu_pkg::alu_op_t op_i,
    input  wire cpu_pkg::data_t   op1_i,
    input  wire cpu_pkg::data_t   op2_i,
    input  wire                   carry_i,
    output cpu_pkg::data_t        result_o,
    output cpu_pkg::flags_t       flags_o
);

    logic       cin;
    logic [8:0] add_w;          // Bit 8 is carry out
    logic [8:0] sub_w;          // Bit 8 is borrow
    logic [4:0] add_h;
    logic [4:0] sub_h;
    logic [8:0] wide;
    logic       half;
    logic       ovf;
    logic       use_ovf;        // P/V as overflow, else parity

    always_comb begin
        cin   = carry_i & ((op_i == `CPU_ALU_ADC) | (op_i == `CPU_ALU_SBC));
        add_w = {1'b0, op1_i} + {1'b0, op2_i} + {8'b0, cin};
        sub_w = {1'b0, op1_i} - {1'b0, op2_i} - {8'b0, cin};
        add_h = {1'b0, op1_i[3:0]} + {1'b0, op2_i[3:0]} + {4'b0, cin};
        sub_h = {1'b0, op1_i[3:0]} - {1'b0, op2_i[3:0]} - {4'b0, cin};

        wide    = 9'd0;
        half    = 1'b0;
        ovf     = 1'b0;
        use_ovf = 1'b0;

        case (op_i)
            `CPU_ALU_ADD, `CPU_ALU_ADC: begin
                wide    = add_w;
                half    = add_h[4];
                ovf     = (op1_i[7] == op2_i[7]) && (add_w[7] != op1_i[7]);
                use_ovf = 1'b1;
            end
            `CPU_ALU_SUB, `CPU_ALU_SBC: begin
                wide    = sub_w;
                half    = sub_h[4];
                ovf     = (op1_i[7] != op2_i[7]) && (sub_w[7] != op1_i[7]);
                use_ovf = 1'b1;
            end
            `CPU_ALU_CP: begin          // Subtract, P/V stays parity
                wide = sub_w;
                half = sub_h[4];
            end
            `CPU_ALU_AND: wide = {1'b0, op1_i & op2_i};
            `CPU_ALU_XOR: wide = {1'b0, op1_i ^ op2_i};
            `CPU_ALU_OR:  wide = {1'b0, op1_i | op2_i};
            default:      wide = 9'd0;
        endcase

        result_o = wide[7:0];

        // Bit 1 fixed high, bits 3 and 5 low
        flags_o             = 8'h02;
        flags_o[`CPU_FLAG_S] = wide[7];
        flags_o[`CPU_FLAG_Z] = (wide[7:0] == 8'h00);
        flags_o[`CPU_FLAG_A] = half;
        flags_o[`CPU_FLAG_P] = use_ovf ? ovf : ~^wide[7:0];
        flags_o[`CPU_FLAG_C] = wide[8];     // Zero for logical ops
    end

endmodule

`default_nettype wire

// ==== cpu_control.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defines.svh"

module cpu_control (
    input  wire                    pin_clk,
    input  wire                    reset_i,
    input  wire cpu_pkg::data_t    mem_rdata_i,
    output cpu_pkg::addr_t         mem_addr_o,
    output cpu_pkg::data_t         mem_wdata_o,
    output logic                   mem_we_o,
    output cpu_pkg::data_t         io_addr_o,
    output cpu_pkg::data_t         io_data_o,
    output logic                   io_we_o,
    cpu_reg_if.ctrl                rif,
    output cpu_pkg::alu_op_t       alu_op_o,
    output cpu_pkg::data_t         alu_op1_o,
    output cpu_pkg::data_t         alu_op2_o,
    input  wire cpu_pkg::data_t    alu_result_i,
    input  wire cpu_pkg::flags_t   alu_flags_i
);

    cpu_pkg::step_t   step_q;
    cpu_pkg::addr_t   pc_q;
    cpu_pkg::addr_t   cursor_q;         // HL or the nn operand
    cpu_pkg::data_t   opcode_q;
    cpu_pkg::data_t   data_q;           // Immediate, moved byte, ALU operand 2
    cpu_pkg::data_t   op1_q;
    cpu_pkg::alu_op_t alu_op_q;

    cpu_pkg::data_t    opcode;
    cpu_pkg::reg_sel_t dst;
    cpu_pkg::reg_sel_t src;
    cpu_pkg::pair_sel_t pair;
    logic              use_cursor;

    // ------------------------------------------------------------------------
    // Decode
    // ------------------------------------------------------------------------

    // Opcode comes straight off the bus in T0
    assign opcode = (step_q == cpu_pkg::T0) ? mem_rdata_i : opcode_q;
    assign dst    = opcode[5:3];
    assign src    = opcode[2:0];
    assign pair   = opcode[5:4];

    logic is_halt, is_ld_rr, is_ld_ri, is_ld_rp, is_sta;
    logic is_alu_r, is_alu_i, is_jp, is_out, multi;
    logic cc_flag, take;

    assign is_halt  = (opcode == 8'h76);
    assign is_ld_rr = (opcode[7:6] == 2'b01) && !is_halt;
    assign is_ld_ri = (opcode[7:6] == 2'b00) && (opcode[2:0] == 3'b110);
    assign is_ld_rp = (opcode[7:6] == 2'b00) && (opcode[3:0] == 4'b0001) &&
                      (opcode[5:4] != 2'b11);
    assign is_sta   = (opcode == 8'h32);
    assign is_alu_r = (opcode[7:6] == 2'b10);
    assign is_alu_i = (opcode[7:6] == 2'b11) && (opcode[2:0] == 3'b110);
    assign is_jp    = (opcode == 8'hC3) ||
                      ((opcode[7:6] == 2'b11) && (opcode[2:0] == 3'b010));
    assign is_out   = (opcode == 8'hD3);

    // Anything else finishes in T0
    assign multi = is_ld_rr | is_ld_ri | is_ld_rp | is_sta |
                   is_alu_r | is_alu_i | is_jp | is_out;

    // Condition code, bit 0 set means unconditional JP
    always_comb begin
        case (opcode[5:4])
            2'b00:   cc_flag = rif.flags[`CPU_FLAG_Z];    // NZ Z
            2'b01:   cc_flag = rif.flags[`CPU_FLAG_C];    // NC C
            2'b10:   cc_flag = rif.flags[`CPU_FLAG_P];    // PO PE
            default: cc_flag = rif.flags[`CPU_FLAG_S];    // P M
        endcase
        take = opcode[0] || (cc_flag == opcode[3]);
    end

    // ------------------------------------------------------------------------
    // Strobes and bus addressing for the current step
    // ------------------------------------------------------------------------

    always_comb begin
        use_cursor     = 1'b0;
        mem_we_o       = 1'b0;
        io_we_o        = 1'b0;
        rif.sel8       = src;
        rif.sel_pair   = `CPU_PAIR_HL;
        rif.wr8        = 1'b0;
        rif.wr16       = 1'b0;
        rif.wr_flags   = 1'b0;
        rif.wdata      = data_q;
        rif.wdata_hi   = mem_rdata_i;
        rif.flags_new  = alu_flags_i;

        case (step_q)
            cpu_pkg::T1: begin
                // Source operand from (HL)
                if ((is_ld_rr || is_alu_r) && src == `CPU_REG_M)
                    use_cursor = 1'b1;
                io_we_o = is_out;       // Port number is on the bus now
            end
            cpu_pkg::T2: begin
                if (is_ld_rp) begin
                    rif.wr16     = 1'b1;
                    rif.sel_pair = pair;
                end
                if (is_ld_rr || is_ld_ri) begin
                    rif.sel8   = dst;
                    rif.wr8    = (dst != `CPU_REG_M);
                    mem_we_o   = (dst == `CPU_REG_M);
                    use_cursor = (dst == `CPU_REG_M);
                end
                if (is_alu_r || is_alu_i) begin
                    rif.sel8     = `CPU_REG_A;
                    rif.wdata    = alu_result_i;
                    rif.wr8      = (alu_op_q != `CPU_ALU_CP);   // CP only sets flags
                    rif.wr_flags = 1'b1;
                end
            end
            cpu_pkg::T3: begin
                use_cursor = is_sta;
                mem_we_o   = is_sta;
            end
            default: ;
        endcase
    end

    assign mem_addr_o  = use_cursor ? cursor_q : pc_q;
    assign mem_wdata_o = data_q;
    assign io_addr_o   = mem_rdata_i;
    assign io_data_o   = rif.acc;

    assign alu_op_o  = alu_op_q;
    assign alu_op1_o = op1_q;
    assign alu_op2_o = data_q;

    // ------------------------------------------------------------------------
    // Sequencer
    // ------------------------------------------------------------------------

    always_ff @(posedge pin_clk) begin
        if (reset_i) begin
            step_q <= cpu_pkg::T0;
            pc_q   <= '0;
        end else begin
            case (step_q)
                cpu_pkg::T0: begin
                    opcode_q <= mem_rdata_i;
                    cursor_q <= rif.rd_pair;        // HL
                    op1_q    <= rif.acc;
                    alu_op_q <= opcode[5:3];
                    if (!is_halt) pc_q <= pc_q + 1'b1;  // HALT refetches itself
                    step_q <= multi ? cpu_pkg::T1 : cpu_pkg::T0;
                end
                cpu_pkg::T1: begin
                    // Register source, else the byte on the bus
                    if ((is_ld_rr || is_alu_r) && src != `CPU_REG_M)
                        data_q <= rif.rd8;
                    else
                        data_q <= mem_rdata_i;
                    if (is_sta || is_jp) cursor_q[7:0] <= mem_rdata_i;
                    if (!(is_ld_rr || is_alu_r)) pc_q <= pc_q + 1'b1;
                    step_q <= is_out ? cpu_pkg::T0 : cpu_pkg::T2;
                end
                cpu_pkg::T2: begin
                    if (is_ld_rp || is_sta || is_jp) pc_q <= pc_q + 1'b1;
                    if (is_sta || is_jp) cursor_q[15:8] <= mem_rdata_i;
                    if (is_sta) data_q <= rif.acc;
                    step_q <= (is_ld_rr || is_sta || is_jp) ? cpu_pkg::T3 : cpu_pkg::T0;
                end
                default: begin
                    if (is_jp && take) pc_q <= cursor_q;
                    step_q <= cpu_pkg::T0;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== cpu_core.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defines.svh"

module cpu_core (
    input  wire                 pin_clk,
    input  wire                 reset_i,
    output wire cpu_pkg::addr_t mem_addr_o,
    input  wire cpu_pkg::data_t mem_rdata_i,
    output wire cpu_pkg::data_t mem_wdata_o,
    output wire                 mem_we_o,
    output wire cpu_pkg::data_t io_addr_o,
    output wire cpu_pkg::data_t io_data_o,
    output wire                 io_we_o
);

    cpu_pkg::alu_op_t alu_op;
    cpu_pkg::data_t   alu_op1;
    cpu_pkg::data_t   alu_op2;
    cpu_pkg::data_t   alu_result;
    cpu_pkg::flags_t  alu_flags;

    cpu_reg_if reg_bus ();

    cpu_control u_control (
        .pin_clk      (pin_clk),
        .reset_i      (reset_i),
        .mem_rdata_i  (mem_rdata_i),
        .mem_addr_o   (mem_addr_o),
        .mem_wdata_o  (mem_wdata_o),
        .mem_we_o     (mem_we_o),
        .io_addr_o    (io_addr_o),
        .io_data_o    (io_data_o),
        .io_we_o      (io_we_o),
        .rif          (reg_bus.ctrl),
        .alu_op_o     (alu_op),
        .alu_op1_o    (alu_op1),
        .alu_op2_o    (alu_op2),
        .alu_result_i (alu_result),
        .alu_flags_i  (alu_flags)
    );

    cpu_alu u_alu (
        .op_i     (alu_op),
        .op1_i    (alu_op1),
        .op2_i    (alu_op2),
        .carry_i  (reg_bus.flags[`CPU_FLAG_C]),     // For ADC and SBC
        .result_o (alu_result),
        .flags_o  (alu_flags)
    );

    cpu_regfile u_regfile (
        .pin_clk (pin_clk),
        .reset_i (reset_i),
        .rif     (reg_bus.regs)
    );

endmodule

`default_nettype wire

// ==== cpu_defines.svh ====
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// Bus widths
`define CPU_DATA_W      8
`define CPU_ADDR_W      16

// Flag bit positions in F
`define CPU_FLAG_C      0
`define CPU_FLAG_P      2
`define CPU_FLAG_A      4
`define CPU_FLAG_Z      6
`define CPU_FLAG_S      7

`define CPU_FLAGS_RESET 8'h40       // Z set, rest clear

// ALU codes, same order as opcode bits 5:3
`define CPU_ALU_ADD     3'd0
`define CPU_ALU_ADC     3'd1
`define CPU_ALU_SUB     3'd2
`define CPU_ALU_SBC     3'd3
`define CPU_ALU_AND     3'd4
`define CPU_ALU_XOR     3'd5
`define CPU_ALU_OR      3'd6
`define CPU_ALU_CP      3'd7

// 8-bit register numbers
`define CPU_REG_B       3'd0
`define CPU_REG_C       3'd1
`define CPU_REG_D       3'd2
`define CPU_REG_E       3'd3
`define CPU_REG_H       3'd4
`define CPU_REG_L       3'd5
`define CPU_REG_M       3'd6        // (HL) memory operand
`define CPU_REG_A       3'd7

// Register pairs
`define CPU_PAIR_BC     2'd0
`define CPU_PAIR_DE     2'd1
`define CPU_PAIR_HL     2'd2

`endif

// ==== cpu_pkg.sv ====
`default_nettype none

`include "cpu_defines.svh"

package cpu_pkg;

    // ------------------------------------------------------------------------
    // Data path types
    // ------------------------------------------------------------------------

    typedef logic [`CPU_DATA_W-1:0] data_t;     // One byte
    typedef logic [`CPU_ADDR_W-1:0] addr_t;     // Byte address
    typedef logic [`CPU_DATA_W-1:0] flags_t;    // S Z 0 A 0 P 1 C

    // ------------------------------------------------------------------------
    // Decode field types
    // ------------------------------------------------------------------------

    typedef logic [2:0] alu_op_t;               // Opcode bits 5:3
    typedef logic [2:0] reg_sel_t;              // B C D E H L (HL) A
    typedef logic [1:0] pair_sel_t;             // BC DE HL

    // Execution step inside one instruction
    // Every instruction starts at T0 with the opcode on the bus
    typedef enum logic [1:0] {
        T0,
        T1,
        T2,
        T3
    } step_t;

endpackage

`default_nettype wire

// ==== cpu_props.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_props (
    input wire pin_clk,
    input wire reset_i,
    input wire mem_we_i,
    input wire io_we_i
);

    // Each write strobe lasts one cycle
    a_mem_we_single: assert property (@(posedge pin_clk) disable iff (reset_i)
        mem_we_i |=> !mem_we_i)
        else $error("mem_we_o stayed high for two cycles in a row");

    a_io_we_single: assert property (@(posedge pin_clk) disable iff (reset_i)
        io_we_i |=> !io_we_i)
        else $error("io_we_o stayed high for two cycles in a row");

    a_one_strobe: assert property (@(posedge pin_clk) disable iff (reset_i)
        !(mem_we_i && io_we_i))
        else $error("mem_we_o and io_we_o high in the same cycle");

    a_quiet_after_reset: assert property (@(posedge pin_clk)
        reset_i |=> !(mem_we_i || io_we_i))
        else $error("write strobe high in the cycle after reset");

endmodule

bind cpu_core cpu_props u_props (
    .pin_clk  (pin_clk),
    .reset_i  (reset_i),
    .mem_we_i (mem_we_o),
    .io_we_i  (io_we_o)
);

`default_nettype wire

// ==== cpu_reg_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface cpu_reg_if;

    // Control side
    cpu_pkg::reg_sel_t  sel8;
    cpu_pkg::pair_sel_t sel_pair;
    logic               wr8;
    logic               wr16;
    cpu_pkg::data_t     wdata;          // 8-bit value or pair low byte
    cpu_pkg::data_t     wdata_hi;       // Pair high byte
    logic               wr_flags;
    cpu_pkg::flags_t    flags_new;

    // Register file side
    cpu_pkg::data_t     rd8;
    cpu_pkg::addr_t     rd_pair;
    cpu_pkg::data_t     acc;
    cpu_pkg::flags_t    flags;

    modport ctrl (
        output sel8, sel_pair, wr8, wr16, wdata, wdata_hi, wr_flags, flags_new,
        input  rd8, rd_pair, acc, flags
    );

    modport regs (
        input  sel8, sel_pair, wr8, wr16, wdata, wdata_hi, wr_flags, flags_new,
        output rd8, rd_pair, acc, flags
    );

endinterface

`default_nettype wire

// ==== cpu_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defines.svh"

module cpu_regfile (
    input  wire     pin_clk,
    input  wire     reset_i,
    cpu_reg_if.regs rif
);

    cpu_pkg::data_t  b, c, d, e, h, l, a;
    cpu_pkg::flags_t f;

    // 8-bit read, (HL) slot reads as zero
    always_comb begin
        case (rif.sel8)
            `CPU_REG_B: rif.rd8 = b;
            `CPU_REG_C: rif.rd8 = c;
            `CPU_REG_D: rif.rd8 = d;
            `CPU_REG_E: rif.rd8 = e;
            `CPU_REG_H: rif.rd8 = h;
            `CPU_REG_L: rif.rd8 = l;
            `CPU_REG_A: rif.rd8 = a;
            default:    rif.rd8 = 8'h00;
        endcase

        case (rif.sel_pair)
            `CPU_PAIR_BC: rif.rd_pair = {b, c};
            `CPU_PAIR_DE: rif.rd_pair = {d, e};
            `CPU_PAIR_HL: rif.rd_pair = {h, l};
            default:      rif.rd_pair = 16'h0000;
        endcase
    end

    assign rif.acc   = a;
    assign rif.flags = f;

    always_ff @(posedge pin_clk) begin
        if (reset_i) begin
            {b, c, d, e, h, l, a} <= '0;
            f <= `CPU_FLAGS_RESET;
        end else if (rif.wr16) begin
            case (rif.sel_pair)
                `CPU_PAIR_BC: {b, c} <= {rif.wdata_hi, rif.wdata};
                `CPU_PAIR_DE: {d, e} <= {rif.wdata_hi, rif.wdata};
                `CPU_PAIR_HL: {h, l} <= {rif.wdata_hi, rif.wdata};
                default: ;
            endcase
        end else begin
            if (rif.wr8) begin
                case (rif.sel8)
                    `CPU_REG_B: b <= rif.wdata;
                    `CPU_REG_C: c <= rif.wdata;
                    `CPU_REG_D: d <= rif.wdata;
                    `CPU_REG_E: e <= rif.wdata;
                    `CPU_REG_H: h <= rif.wdata;
                    `CPU_REG_L: l <= rif.wdata;
                    `CPU_REG_A: a <= rif.wdata;
                    default: ;              // (HL) goes to memory
                endcase
            end
            if (rif.wr_flags) f <= rif.flags_new;   // Alongside the A write
        end
    end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# Build the CPU testbench with Verilator, run it and look for the pass line
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f src.f --top-module tb_cpu -o tb_cpu_sim
./obj_dir/tb_cpu_sim | tee sim.log

if grep -q "^Done: no errors$" sim.log; then
    echo "PASS"
else
    echo "FAIL"
    exit 1
fi

// ==== src.f ====
+incdir+.
cpu_pkg.sv
cpu_reg_if.sv
cpu_alu.sv
cpu_regfile.sv
cpu_control.sv
cpu_core.sv
cpu_props.sv
tb_cpu.sv

// ==== tb_cpu.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defines.svh"

module tb_cpu;

    localparam int PROG_LEN   = 120;        // Random instructions before the final OUT
    localparam int RUN_LIMIT  = 20000;      // Cycles allowed to reach the final OUT
    localparam int MODEL_STEP = 4000;

    logic           pin_clk;
    logic           reset_i;
    cpu_pkg::addr_t mem_addr;
    cpu_pkg::data_t mem_rdata;
    cpu_pkg::data_t mem_wdata;
    logic           mem_we;
    cpu_pkg::data_t io_addr;
    cpu_pkg::data_t io_data;
    logic           io_we;

    cpu_pkg::data_t  mem     [0:65535];     // DUT memory
    cpu_pkg::data_t  image   [0:65535];     // Program as generated
    cpu_pkg::data_t  ref_mem [0:65535];     // Model memory
    cpu_pkg::data_t  rf      [0:7];         // Model registers, slot 6 unused
    cpu_pkg::flags_t rf_f;
    cpu_pkg::addr_t  gen_pc;
    logic [15:0]     exp_io  [$];           // {port, data}
    logic [23:0]     exp_mem [$];           // {address, data}
    logic            final_seen = 1'b0;

    cpu_core u_cpu_core (
        .pin_clk     (pin_clk),
        .reset_i     (reset_i),
        .mem_addr_o  (mem_addr),
        .mem_rdata_i (mem_rdata),
        .mem_wdata_o (mem_wdata),
        .mem_we_o    (mem_we),
        .io_addr_o   (io_addr),
        .io_data_o   (io_data),
        .io_we_o     (io_we)
    );

    assign mem_rdata = mem[mem_addr];       // Asynchronous read

    always @(posedge pin_clk) begin
        if (mem_we) mem[mem_addr] <= mem_wdata;
    end

    initial begin
        pin_clk = 1'b0;
        forever #4 pin_clk = ~pin_clk;
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Done: errors found");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [23:0] expected,
                               input logic [23:0] actual);
        if (expected !== actual)
            fail_run($sformatf("error: %s expected %h actual %h", name, expected, actual));
    endtask

    // ------------------------------------------------------------------------
    // Random program
    // ------------------------------------------------------------------------

    function automatic cpu_pkg::data_t rand_byte();
        return 8'($urandom);
    endfunction

    // Destination without H and L, so HL stays in the data page
    function automatic cpu_pkg::reg_sel_t pick_dest();
        cpu_pkg::reg_sel_t pick;
        pick = 3'($urandom_range(0, 5));
        return (pick < 3'd4) ? pick : pick + 3'd2;  // 4 and 5 map to (HL) and A
    endfunction

    task automatic emit_byte(input cpu_pkg::data_t b);
        image[gen_pc] = b;
        gen_pc = gen_pc + 16'd1;
    endtask

    task automatic build_program();
        cpu_pkg::addr_t     start [0:PROG_LEN];
        cpu_pkg::addr_t     fix_at [$];
        int                 fix_to [$];
        cpu_pkg::addr_t     at;
        cpu_pkg::reg_sel_t  dst;
        cpu_pkg::reg_sel_t  src;
        cpu_pkg::pair_sel_t pair;
        int                 a;
        int                 i;
        int                 kind;
        int                 tgt;
        int                 until_out;

        for (a = 0; a < 65536; a++)
            image[a] = 8'(a) ^ 8'(a >> 8) ^ 8'h3C;
        gen_pc    = 16'h0000;
        until_out = 3;
        for (i = 0; i < PROG_LEN; i++) begin
            start[i] = gen_pc;
            if (i == 0) kind = 3;               // HL into the data page first
            else if (until_out == 0) kind = 10;
            else kind = int'($urandom_range(0, 9));
            until_out = (kind == 10) ? int'($urandom_range(2, 4)) : until_out - 1;
            case (kind)
                0: emit_byte(8'h00);
                1: begin                        // LD r,i8
                    emit_byte({2'b00, pick_dest(), 3'b110});
                    emit_byte(rand_byte());
                end
                2: begin                        // LD r,r
                    dst = pick_dest();
                    src = 3'($urandom_range(0, 7));
                    if (dst == `CPU_REG_M && src == `CPU_REG_M) src = `CPU_REG_A;
                    emit_byte({2'b01, dst, src});
                end
                3: begin                        // LD rp,i16
                    pair = (i == 0) ? `CPU_PAIR_HL : 2'($urandom_range(0, 2));
                    emit_byte({2'b00, pair, 4'b0001});
                    emit_byte(rand_byte());
                    emit_byte((pair == `CPU_PAIR_HL) ? 8'h80 : rand_byte());
                end
                4, 5: emit_byte({2'b10, 3'($urandom), 3'($urandom)});
                6: begin
                    emit_byte({2'b11, 3'($urandom), 3'b110});
                    emit_byte(rand_byte());
                end
                7: begin                        // LD (nn),A into the data page
                    emit_byte(8'h32);
                    emit_byte(rand_byte());
                    emit_byte(8'h80);
                end
                8, 9: begin
                    emit_byte(($urandom_range(0, 8) == 0) ? 8'hC3 :
                              {2'b11, 3'($urandom), 3'b010});
                    fix_at.push_back(gen_pc);
                    tgt = i + int'($urandom_range(1, 3));   // Always forward
                    fix_to.push_back((tgt > PROG_LEN) ? PROG_LEN : tgt);
                    emit_byte(8'h00);
                    emit_byte(8'h00);
                end
                default: begin                  // Port FFh marks the end
                    emit_byte(8'hD3);
                    emit_byte(8'($urandom_range(0, 254)));
                end
            endcase
        end
        start[PROG_LEN] = gen_pc;
        emit_byte(8'hD3);
        emit_byte(8'hFF);
        emit_byte(8'h76);
        while (fix_at.size() > 0) begin
            at  = fix_at.pop_front();
            tgt = fix_to.pop_front();
            image[at]         = start[tgt][7:0];
            image[at + 16'd1] = start[tgt][15:8];
        end
        ref_mem = image;
    endtask

    // ------------------------------------------------------------------------
    // Reference interpreter
    // ------------------------------------------------------------------------

    function automatic logic parity_even(input cpu_pkg::data_t v);
        int ones;
        int k;
        ones = 0;
        for (k = 0; k < 8; k++) ones += int'(v[k]);
        return (ones % 2) == 0;
    endfunction

    function automatic int signed_of(input cpu_pkg::data_t v);
        return (v > 8'd127) ? int'(v) - 256 : int'(v);
    endfunction

    task automatic model_alu(input cpu_pkg::alu_op_t op, input cpu_pkg::data_t b);
        int             x;
        int             y;
        int             cin;
        int             res;
        int             sres;
        logic           hf;
        logic           cf;
        cpu_pkg::data_t r8;

        x    = int'(rf[`CPU_REG_A]);
        y    = int'(b);
        cin  = (op == `CPU_ALU_ADC || op == `CPU_ALU_SBC) ? int'(rf_f[`CPU_FLAG_C]) : 0;
        sres = 0;
        hf   = 1'b0;
        cf   = 1'b0;
        case (op)
            `CPU_ALU_ADD, `CPU_ALU_ADC: begin
                res  = x + y + cin;
                sres = signed_of(rf[`CPU_REG_A]) + signed_of(b) + cin;
                cf   = res > 255;
                hf   = (x % 16) + (y % 16) + cin > 15;
            end
            `CPU_ALU_AND: res = x & y;
            `CPU_ALU_XOR: res = x ^ y;
            `CPU_ALU_OR:  res = x | y;
            default: begin                      // SUB SBC CP
                res  = x - y - cin;
                sres = signed_of(rf[`CPU_REG_A]) - signed_of(b) - cin;
                cf   = res < 0;
                hf   = (x % 16) - (y % 16) - cin < 0;
            end
        endcase
        r8   = 8'(res);
        rf_f = 8'h02;
        rf_f[`CPU_FLAG_S] = r8[7];
        rf_f[`CPU_FLAG_Z] = (r8 == 8'h00);
        rf_f[`CPU_FLAG_A] = hf;
        rf_f[`CPU_FLAG_P] = (op < `CPU_ALU_AND) ? (sres > 127 || sres < -128) : parity_even(r8);
        rf_f[`CPU_FLAG_C] = cf;
        if (op != `CPU_ALU_CP) rf[`CPU_REG_A] = r8;
    endtask

    function automatic cpu_pkg::data_t model_read(input cpu_pkg::reg_sel_t sel);
        return (sel == `CPU_REG_M) ? ref_mem[{rf[`CPU_REG_H], rf[`CPU_REG_L]}] : rf[sel];
    endfunction

    task automatic model_write(input cpu_pkg::reg_sel_t sel, input cpu_pkg::data_t v);
        cpu_pkg::addr_t hl;
        hl = {rf[`CPU_REG_H], rf[`CPU_REG_L]};
        if (sel == `CPU_REG_M) begin
            ref_mem[hl] = v;
            exp_mem.push_back({hl, v});
        end else begin
            rf[sel] = v;
        end
    endtask

    task automatic run_model();
        cpu_pkg::addr_t pc;
        cpu_pkg::data_t op;
        cpu_pkg::data_t b1;
        cpu_pkg::data_t b2;
        logic           taken;
        int             steps;
        int             k;

        for (k = 0; k < 8; k++) rf[k] = 8'h00;
        rf_f  = `CPU_FLAGS_RESET;
        pc    = 16'h0000;
        steps = 0;
        op    = ref_mem[pc];
        while (op != 8'h76) begin
            if (steps == MODEL_STEP) fail_run("reference model never reached HALT");
            b1 = ref_mem[pc + 16'd1];
            b2 = ref_mem[pc + 16'd2];
            if (op == 8'h00) begin
                pc = pc + 16'd1;
            end else if (op == 8'h32) begin
                ref_mem[{b2, b1}] = rf[`CPU_REG_A];
                exp_mem.push_back({b2, b1, rf[`CPU_REG_A]});
                pc = pc + 16'd3;
            end else if (op == 8'hD3) begin
                exp_io.push_back({b1, rf[`CPU_REG_A]});
                pc = pc + 16'd2;
            end else if (op == 8'hC3 || (op[7:6] == 2'b11 && op[2:0] == 3'b010)) begin
                case (op[5:3])
                    3'd0: taken = !rf_f[`CPU_FLAG_Z];   // NZ
                    3'd1: taken = rf_f[`CPU_FLAG_Z];
                    3'd2: taken = !rf_f[`CPU_FLAG_C];   // NC
                    3'd3: taken = rf_f[`CPU_FLAG_C];
                    3'd4: taken = !rf_f[`CPU_FLAG_P];   // PO
                    3'd5: taken = rf_f[`CPU_FLAG_P];
                    3'd6: taken = !rf_f[`CPU_FLAG_S];   // P
                    default: taken = rf_f[`CPU_FLAG_S];
                endcase
                if (op == 8'hC3) taken = 1'b1;
                pc = taken ? {b2, b1} : pc + 16'd3;
            end else if (op[7:6] == 2'b01) begin
                model_write(op[5:3], model_read(op[2:0]));
                pc = pc + 16'd1;
            end else if (op[7:6] == 2'b10) begin
                model_alu(op[5:3], model_read(op[2:0]));
                pc = pc + 16'd1;
            end else if (op[7:6] == 2'b11 && op[2:0] == 3'b110) begin
                model_alu(op[5:3], b1);
                pc = pc + 16'd2;
            end else if (op[7:6] == 2'b00 && op[2:0] == 3'b110) begin
                model_write(op[5:3], b1);
                pc = pc + 16'd2;
            end else if (op[7:6] == 2'b00 && op[3:0] == 4'b0001 && op[5:4] != 2'b11) begin
                rf[{op[5:4], 1'b0}] = b2;       // High byte to B, D or H
                rf[{op[5:4], 1'b1}] = b1;
                pc = pc + 16'd3;
            end else begin
                fail_run("reference model met an opcode outside the generated set");
            end
            steps++;
            op = ref_mem[pc];
        end
    endtask

    // ------------------------------------------------------------------------
    // Monitor and run control
    // ------------------------------------------------------------------------

    always @(negedge pin_clk) begin
        if (!reset_i && io_we) begin
            if (exp_io.size() == 0)
                fail_run("port write seen after the expected sequence ended");
            else
                check_value("port write", 24'(exp_io.pop_front()), 24'({io_addr, io_data}));
            if (io_addr == 8'hFF) final_seen = 1'b1;
        end
        if (!reset_i && mem_we) begin
            if (exp_mem.size() == 0)
                fail_run("memory write seen after the expected sequence ended");
            else
                check_value("memory write", exp_mem.pop_front(), {mem_addr, mem_wdata});
        end
    end

    initial begin
        int i;
        int wait_cyc;

        reset_i <= 1'b1;
        void'($urandom(32'h548e));
        build_program();
        run_model();
        for (i = 0; i < 65536; i++) mem[i] <= image[i];

        for (i = 0; i < 8; i++) @(posedge pin_clk);
        reset_i <= 1'b0;
        @(negedge pin_clk);
        check_value("first fetch address", 24'h000000, 24'(mem_addr));
        check_value("strobes after reset", 24'h000000, 24'({mem_we, io_we}));

        wait_cyc = 0;
        while (!final_seen && wait_cyc < RUN_LIMIT) begin
            @(posedge pin_clk);
            wait_cyc++;
        end
        if (!final_seen) fail_run("timed out waiting for the final port write to FFh");

        // HALT spins on itself, any write now is unexpected
        for (i = 0; i < 50; i++) @(posedge pin_clk);

        if (exp_io.size() == 0 && exp_mem.size() == 0) begin
            $display("Done: no errors");
            $finish;
        end else begin
            fail_run("some expected writes never appeared");
        end
    end

endmodule

`default_nettype wire
